// ==== Bender.yml ====
package:
  name: mac_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/mac_rx_pkg.sv
      - rtl/rx_frame_delineate.sv
      - rtl/rx_fcs_check.sv
      - rtl/rx_stream_out.sv
      - rtl/mac_rx.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/mac_rx_asserts.sv
      - dv/mac_rx_tb.sv

// ==== dv/mac_rx_asserts.sv ====
`timescale 1ns/1ps

module mac_rx_asserts (
    input logic                               rx_clk,
    input logic                               rx_reset,
    input logic [mac_rx_pkg::DATA_NBYTES-1:0] m00_axis_tkeep,
    input logic                               m00_axis_tvalid,
    input logic                               m00_axis_tlast,
    input logic                               m00_axis_tuser
);

    int fail_cnt = 0;

    // A reset cycle leaves the stream idle
    tvalid_low_in_reset: assert property (
        @(posedge rx_clk) rx_reset |=> !m00_axis_tvalid
    ) else begin
        $error("m00_axis_tvalid high following a reset cycle");
        fail_cnt++;
    end

    tkeep_contiguous: assert property (
        @(posedge rx_clk) disable iff (rx_reset)
        m00_axis_tvalid |-> m00_axis_tkeep inside {4'b0001, 4'b0011, 4'b0111, 4'b1111}
    ) else begin
        $error("m00_axis_tkeep empty or not contiguous from lane 0");
        fail_cnt++;
    end

    tkeep_full_unless_last: assert property (
        @(posedge rx_clk) disable iff (rx_reset)
        (m00_axis_tvalid && !m00_axis_tlast) |-> (m00_axis_tkeep == 4'b1111)
    ) else begin
        $error("partial m00_axis_tkeep on a beat without tlast");
        fail_cnt++;
    end

    tuser_only_on_last: assert property (
        @(posedge rx_clk) disable iff (rx_reset)
        m00_axis_tuser |-> (m00_axis_tvalid && m00_axis_tlast)
    ) else begin
        $error("m00_axis_tuser high outside a tlast beat");
        fail_cnt++;
    end

endmodule

// ==== dv/mac_rx_tb.sv ====
`timescale 1ns/1ps

module mac_rx_tb;

    import mac_rx_pkg::*;

    logic        rx_clk;
    logic        rx_reset;
    logic [31:0] xgmii_rx_data;
    logic [3:0]  xgmii_rx_ctl;
    logic        phy_rx_valid;
    logic [3:0]  term_loc;
    logic [31:0] m00_axis_tdata;
    logic [3:0]  m00_axis_tkeep;
    logic        m00_axis_tvalid;
    logic        m00_axis_tlast;
    logic        m00_axis_tuser;

    // Expected payload bytes plus length and bad flag per frame
    logic [7:0] exp_bytes[$];
    int         exp_len[$];
    bit         exp_bad[$];
    int         bytes_left = 0;
    bit         frame_bad  = 1'b0;
    int         errors     = 0;
    int         timeouts   = 0;

    tb_clock_gen i_clock_gen (.rx_clk(rx_clk), .rx_reset(rx_reset));

    mac_rx i_mac_rx (.*);

    bind mac_rx mac_rx_asserts i_asserts (.*);

    // Reflected CRC-32 with each byte folded in at the low end
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] r;
        r = crc ^ {24'h0, b};
        for (int k = 0; k < 8; k++) begin
            r = r[0] ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("ERROR %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
        errors++;
    endtask

    task automatic drive_word(input logic [31:0] data, input logic [3:0] ctl,
                              input logic [3:0] term, input logic valid);
        @(posedge rx_clk);
        #2;
        xgmii_rx_data = data;
        xgmii_rx_ctl  = ctl;
        term_loc      = term;
        phy_rx_valid  = valid;
    endtask

    task automatic send_idle(input int n);
        repeat (n) drive_word({4{XGMII_IDLE}}, 4'b1111, 4'b0000, 1'b1);
    endtask

    // Zero to two words with phy_rx_valid low and random contents
    task automatic insert_bubbles(input bit enable);
        int n;
        n = enable ? int'($urandom % 3) : 0;
        repeat (n) drive_word($urandom, 4'($urandom), 4'($urandom), 1'b0);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_len.size() != 0 || bytes_left != 0) && cycles < 200) begin
            @(posedge rx_clk);
            cycles++;
        end
        if (exp_len.size() != 0 || bytes_left != 0) begin
            $display("Timeout at %0t ns: frame never fully left the stream output", $time);
            timeouts++;
            exp_bytes.delete();
            exp_len.delete();
            exp_bad.delete();
            bytes_left = 0;
        end
    endtask

    task automatic send_frame(input int len, input int err_at, input bit bad_fcs,
                              input bit bubbles);
        logic [7:0]  fbytes[$];
        logic [31:0] crc;
        logic [31:0] data;
        logic [3:0]  ctl;
        int          total;
        int          idx;
        int          r;
        crc = 32'hFFFF_FFFF;
        for (int i = 0; i < len; i++) begin
            fbytes.push_back((i == err_at) ? XGMII_ERROR : 8'($urandom));
            crc = crc_step(crc, fbytes[i]);
            exp_bytes.push_back(fbytes[i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            fbytes.push_back(crc[8*i +: 8]);
        end
        if (bad_fcs) begin
            idx = len + int'($urandom % 4);
            fbytes[idx] = ~fbytes[idx];
        end
        exp_len.push_back(len);
        exp_bad.push_back(bad_fcs || err_at >= 0 || (len + 4 < MIN_FRAME_BYTES));

        drive_word({{3{PREAMBLE_BYTE}}, XGMII_START}, 4'b0001, 4'b0000, 1'b1);
        insert_bubbles(bubbles);
        drive_word({SFD_BYTE, {3{PREAMBLE_BYTE}}}, 4'b0000, 4'b0000, 1'b1);
        total = len + 4;
        idx   = 0;
        while (total - idx >= 4) begin
            for (int i = 0; i < 4; i++) begin
                data[8*i +: 8] = fbytes[idx + i];
                ctl[i]         = (idx + i == err_at);
            end
            insert_bubbles(bubbles);
            drive_word(data, ctl, 4'b0000, 1'b1);
            idx += 4;
        end

        // Terminate word with idles above the terminate lane
        r    = total - idx;
        data = {4{XGMII_IDLE}};
        ctl  = 4'b1111;
        for (int i = 0; i < r; i++) begin
            data[8*i +: 8] = fbytes[idx + i];
            ctl[i]         = (idx + i == err_at);
        end
        data[8*r +: 8] = XGMII_TERM;
        insert_bubbles(bubbles);
        drive_word(data, ctl, 4'b0001 << r, 1'b1);
        send_idle(3);
        wait_drain();
    endtask

    task automatic check_beat();
        int         n;
        logic [7:0] b;
        if (bytes_left == 0 && exp_len.size() != 0) begin
            bytes_left = exp_len.pop_front();
            frame_bad  = exp_bad.pop_front();
        end
        assert (bytes_left != 0) else begin
            $display("Output beat at %0t ns while no frame was outstanding", $time);
            errors++;
        end
        if (bytes_left != 0) begin
            n = (bytes_left > 4) ? 4 : bytes_left;
            for (int i = 0; i < n; i++) begin
                b = exp_bytes.pop_front();
                assert (m00_axis_tdata[8*i +: 8] == b)
                    else report_mismatch($sformatf("m00_axis_tdata lane %0d", i), b,
                                         m00_axis_tdata[8*i +: 8]);
            end
            assert (m00_axis_tkeep == 4'(4'b1111 >> (4 - n)))
                else report_mismatch("m00_axis_tkeep", 4'(4'b1111 >> (4 - n)), m00_axis_tkeep);
            assert (m00_axis_tlast == (bytes_left <= 4))
                else report_mismatch("m00_axis_tlast", bytes_left <= 4, m00_axis_tlast);
            if (bytes_left <= 4) begin
                assert (m00_axis_tuser == frame_bad)
                    else report_mismatch("m00_axis_tuser", frame_bad, m00_axis_tuser);
            end
            bytes_left -= n;
        end
    endtask

    // Output monitor
    always @(negedge rx_clk) begin
        if (!rx_reset && m00_axis_tvalid) begin
            check_beat();
        end
    end

    initial begin
        int cycles;
        xgmii_rx_data = {4{XGMII_IDLE}};
        xgmii_rx_ctl  = 4'b1111;
        phy_rx_valid  = 1'b0;
        term_loc      = 4'b0000;
        void'($urandom(32'hfd9b));

        cycles = 0;
        while (rx_reset !== 1'b0 && cycles < 20) begin
            @(posedge rx_clk);
            cycles++;
        end
        if (rx_reset !== 1'b0) begin
            $display("Timeout: reset was never released");
            timeouts++;
        end
        send_idle(8);

        // Every terminate lane first and then random lengths
        for (int len = 60; len < 64; len++) begin
            send_frame(len, -1, 1'b0, 1'b0);
        end
        repeat (4) send_frame(60 + int'($urandom % 64), -1, 1'b0, 1'b0);

        send_frame(72, -1, 1'b1, 1'b0);
        send_frame(80, int'($urandom % 80), 1'b0, 1'b0);
        send_frame(40, -1, 1'b0, 1'b0);
        send_frame(59, -1, 1'b0, 1'b0);

        // Same mix again with bubbles inside the frames
        for (int len = 60; len < 64; len++) begin
            send_frame(len, -1, 1'b0, 1'b1);
        end
        repeat (4) send_frame(60 + int'($urandom % 64), -1, bit'($urandom % 2), 1'b1);
        send_frame(76, int'($urandom % 76), 1'b0, 1'b1);
        send_idle(8);

        $display("Closing report: %0d value errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, i_mac_rx.i_asserts.fail_cnt);
        if (errors == 0 && timeouts == 0 && i_mac_rx.i_asserts.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic rx_clk,
    output logic rx_reset
);

    // 40 ns period
    initial begin
        rx_clk = 1'b0;
        forever begin
            #20 rx_clk = ~rx_clk;
        end
    end

    // Reset held over two rising edges, released just after the second
    initial begin
        rx_reset = 1'b1;
        repeat (2) @(posedge rx_clk);
        #2 rx_reset = 1'b0;
    end

endmodule

// ==== include/xgmii_defs.svh ====
`ifndef XGMII_DEFS_SVH
`define XGMII_DEFS_SVH

// XGMII control characters, valid on lanes with ctl set
localparam logic [7:0] XGMII_START = 8'hFB;
localparam logic [7:0] XGMII_TERM  = 8'hFD;
localparam logic [7:0] XGMII_IDLE  = 8'h07;
localparam logic [7:0] XGMII_ERROR = 8'hFE;

// Preamble and start frame delimiter
localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
localparam logic [7:0] SFD_BYTE      = 8'hD5;

`endif

// ==== rtl/mac_rx.sv ====
`timescale 1ns/1ps

module mac_rx (
    input  logic                               rx_clk,
    input  logic                               rx_reset,
    input  logic [mac_rx_pkg::DATA_WIDTH-1:0]  xgmii_rx_data,
    input  logic [mac_rx_pkg::DATA_NBYTES-1:0] xgmii_rx_ctl,
    input  logic                               phy_rx_valid,
    input  logic [mac_rx_pkg::DATA_NBYTES-1:0] term_loc,
    output logic [mac_rx_pkg::DATA_WIDTH-1:0]  m00_axis_tdata,
    output logic [mac_rx_pkg::DATA_NBYTES-1:0] m00_axis_tkeep,
    output logic                               m00_axis_tvalid,
    output logic                               m00_axis_tlast,
    output logic                               m00_axis_tuser
);

    import mac_rx_pkg::*;

    xgmii_word_t xgmii;
    rx_beat_t    beat;
    logic        beat_valid;
    chk_beat_t   chk;
    logic        chk_valid;
    axis_beat_t  out;
    logic        out_valid;

    assign xgmii = '{data: xgmii_rx_data, ctl: xgmii_rx_ctl, term_loc: term_loc};

    rx_frame_delineate i_delineate (
        .rx_clk       (rx_clk),
        .rx_reset     (rx_reset),
        .xgmii        (xgmii),
        .phy_rx_valid (phy_rx_valid),
        .beat         (beat),
        .beat_valid   (beat_valid)
    );

    rx_fcs_check i_fcs_check (
        .rx_clk     (rx_clk),
        .rx_reset   (rx_reset),
        .beat       (beat),
        .beat_valid (beat_valid),
        .chk        (chk),
        .chk_valid  (chk_valid)
    );

    rx_stream_out i_stream_out (
        .rx_clk    (rx_clk),
        .rx_reset  (rx_reset),
        .chk       (chk),
        .chk_valid (chk_valid),
        .out       (out),
        .out_valid (out_valid)
    );

    assign m00_axis_tdata  = out.tdata;
    assign m00_axis_tkeep  = out.tkeep;
    assign m00_axis_tvalid = out_valid;
    assign m00_axis_tlast  = out.tlast;
    assign m00_axis_tuser  = out.tuser;

endmodule

// ==== rtl/mac_rx_pkg.sv ====
package mac_rx_pkg;

    `include "xgmii_defs.svh"

    localparam int DATA_WIDTH  = 32;
    localparam int DATA_NBYTES = DATA_WIDTH / 8;

    // 46 byte minimum payload plus 14 byte header plus FCS
    localparam int MIN_FRAME_BYTES = 64;
    localparam int BYTE_CNT_W      = $clog2(MIN_FRAME_BYTES) + 1;

    // Reflected CRC-32 (IEEE 802.3)
    localparam logic [31:0] CRC_INIT    = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY    = 32'hEDB8_8320;
    localparam logic [31:0] CRC_RESIDUE = 32'hC704_DD7B;

    // One byte through the shift-right CRC, LSB first
    function automatic logic [31:0] crc32_byte(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    typedef struct packed {
        logic [DATA_WIDTH-1:0]  data;
        logic [DATA_NBYTES-1:0] ctl;
        logic [DATA_NBYTES-1:0] term_loc;
    } xgmii_word_t;

    // keep is contiguous from lane 0
    typedef struct packed {
        logic [DATA_WIDTH-1:0]  data;
        logic [DATA_NBYTES-1:0] keep;
        logic                   last;
        logic                   err;
    } rx_beat_t;

    typedef struct packed {
        rx_beat_t beat;
        logic     crc_ok;
    } chk_beat_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]  tdata;
        logic [DATA_NBYTES-1:0] tkeep;
        logic                   tlast;
        logic                   tuser;
    } axis_beat_t;

endpackage

// ==== rtl/rx_fcs_check.sv ====
`timescale 1ns/1ps

module rx_fcs_check (
    input  logic                  rx_clk,
    input  logic                  rx_reset,
    input  mac_rx_pkg::rx_beat_t  beat,
    input  logic                  beat_valid,
    output mac_rx_pkg::chk_beat_t chk,
    output logic                  chk_valid
);

    import mac_rx_pkg::*;

    logic [31:0] crc;
    logic [31:0] crc_calc;
    logic [31:0] crc_rev;
    logic        crc_match;

    always_comb begin
        crc_calc = crc;
        // Lane 0 is the earliest byte on the wire
        for (int i = 0; i < DATA_NBYTES; i++) begin
            if (beat.keep[i]) begin
                crc_calc = crc32_byte(crc_calc, beat.data[8*i +: 8]);
            end
        end

        // Residue is given in normal bit order
        for (int i = 0; i < 32; i++) begin
            crc_rev[i] = crc_calc[31-i];
        end

        crc_match = (crc_rev == CRC_RESIDUE);
    end

    always_ff @(posedge rx_clk) begin
        if (rx_reset) begin
            crc       <= CRC_INIT;
            chk_valid <= 1'b0;
        end else begin
            chk_valid <= beat_valid;
            if (beat_valid) begin
                chk <= '{beat: beat, crc_ok: crc_match};
                if (beat.last) begin
                    crc <= CRC_INIT;
                end else begin
                    crc <= crc_calc;
                end
            end
        end
    end

endmodule

// ==== rtl/rx_frame_delineate.sv ====
`timescale 1ns/1ps

module rx_frame_delineate (
    input  logic                    rx_clk,
    input  logic                    rx_reset,
    input  mac_rx_pkg::xgmii_word_t xgmii,
    input  logic                    phy_rx_valid,
    output mac_rx_pkg::rx_beat_t    beat,
    output logic                    beat_valid
);

    import mac_rx_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_PAYLOAD
    } state_t;

    state_t                 state;
    logic                   is_start;
    logic                   is_preamble;
    logic                   is_term;
    logic                   is_idle;
    logic                   term_bad;
    logic                   err_now;
    logic [DATA_NBYTES-1:0] data_lanes;
    logic [DATA_NBYTES-1:0] err_lanes;
    logic [DATA_NBYTES-1:0] term_chars;

    always_comb begin
        is_start    = xgmii.ctl[0] && (xgmii.data[7:0] == XGMII_START);
        is_preamble = (xgmii.ctl == '0) &&
                      (xgmii.data == {SFD_BYTE, {3{PREAMBLE_BYTE}}});
        is_term     = |xgmii.term_loc;

        // Lanes below the one-hot terminate lane carry data
        data_lanes = is_term ? xgmii.term_loc - 1'b1 : {DATA_NBYTES{1'b1}};

        for (int i = 0; i < DATA_NBYTES; i++) begin
            err_lanes[i]  = xgmii.ctl[i] && (xgmii.data[8*i +: 8] == XGMII_ERROR);
            term_chars[i] = xgmii.ctl[i] && (xgmii.data[8*i +: 8] == XGMII_TERM);
        end

        // Terminate lane that does not hold FD
        term_bad = is_term && !(|(xgmii.term_loc & term_chars));

        // Idle inside a frame means the terminate was lost
        is_idle = !is_term && xgmii.ctl[0] && (xgmii.data[7:0] == XGMII_IDLE);

        err_now = (|(err_lanes & data_lanes)) || term_bad;
    end

    always_ff @(posedge rx_clk) begin
        if (rx_reset) begin
            state      <= ST_IDLE;
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= 1'b0;
            if (phy_rx_valid) begin
                case (state)
                    ST_IDLE: begin
                        if (is_start) begin
                            state <= ST_PREAMBLE;
                        end
                    end
                    ST_PREAMBLE: begin
                        // Nothing sent yet, so a second start just restarts
                        if (is_start) begin
                            state <= ST_PREAMBLE;
                        end else if (is_preamble) begin
                            state <= ST_PAYLOAD;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                    ST_PAYLOAD: begin
                        beat_valid <= 1'b1;
                        if (is_start || is_idle) begin
                            // Close the open frame as bad
                            beat  <= '{data: xgmii.data, keep: '0, last: 1'b1, err: 1'b1};
                            state <= is_start ? ST_PREAMBLE : ST_IDLE;
                        end else begin
                            beat <= '{data: xgmii.data, keep: data_lanes,
                                      last: is_term, err: err_now};
                            if (is_term) begin
                                state <= ST_IDLE;
                            end
                        end
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/rx_stream_out.sv ====
`timescale 1ns/1ps

module rx_stream_out (
    input  logic                   rx_clk,
    input  logic                   rx_reset,
    input  mac_rx_pkg::chk_beat_t  chk,
    input  logic                   chk_valid,
    output mac_rx_pkg::axis_beat_t out,
    output logic                   out_valid
);

    import mac_rx_pkg::*;

    logic [DATA_WIDTH-1:0] hold_old;
    logic [DATA_WIDTH-1:0] hold_new;
    logic [1:0]            hold_cnt;
    axis_beat_t            pend;
    logic                  pend_valid;
    logic [BYTE_CNT_W-1:0] byte_cnt;
    logic                  frame_err;
    logic [2:0]            last_bytes;
    logic [BYTE_CNT_W:0]   frame_len;
    logic                  frame_bad;

    always_comb begin
        case (chk.beat.keep)
            4'b0001: last_bytes = 3'd1;
            4'b0011: last_bytes = 3'd2;
            4'b0111: last_bytes = 3'd3;
            4'b1111: last_bytes = 3'd4;
            default: last_bytes = 3'd0;
        endcase

        frame_len = {1'b0, byte_cnt} + (BYTE_CNT_W + 1)'(last_bytes);
        frame_bad = frame_err || chk.beat.err || !chk.crc_ok ||
                    (frame_len < MIN_FRAME_BYTES);
    end

    // Held beats are always full; only the last input beat can be partial.
    // The FCS spans the last beat and the tail of hold_new, or all of
    // hold_new when the last beat is empty.
    always_ff @(posedge rx_clk) begin
        if (rx_reset) begin
            hold_cnt   <= '0;
            pend_valid <= 1'b0;
            byte_cnt   <= '0;
            frame_err  <= 1'b0;
            out_valid  <= 1'b0;
            out.tlast  <= 1'b0;
            out.tuser  <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            out.tlast <= 1'b0;
            out.tuser <= 1'b0;

            // Second beat of a split frame end
            if (pend_valid) begin
                out        <= pend;
                out_valid  <= 1'b1;
                pend_valid <= 1'b0;
            end

            if (chk_valid && !chk.beat.last) begin
                if (byte_cnt < MIN_FRAME_BYTES) begin
                    byte_cnt <= byte_cnt + BYTE_CNT_W'(DATA_NBYTES);
                end
                frame_err <= frame_err | chk.beat.err;
                hold_new  <= chk.beat.data;
                if (hold_cnt != 2'd0) begin
                    hold_old <= hold_new;
                end
                if (hold_cnt == 2'd2) begin
                    out <= '{tdata: hold_old, tkeep: {DATA_NBYTES{1'b1}},
                             tlast: 1'b0, tuser: 1'b0};
                    out_valid <= 1'b1;
                end else begin
                    hold_cnt <= hold_cnt + 2'd1;
                end
            end else if (chk_valid) begin
                byte_cnt  <= '0;
                frame_err <= 1'b0;
                hold_cnt  <= '0;
                if (last_bytes != 3'd0) begin
                    // hold_new ends the frame, trimmed to the same lanes
                    if (hold_cnt == 2'd2) begin
                        out <= '{tdata: hold_old, tkeep: {DATA_NBYTES{1'b1}},
                                 tlast: 1'b0, tuser: 1'b0};
                        out_valid  <= 1'b1;
                        pend       <= '{tdata: hold_new, tkeep: chk.beat.keep,
                                        tlast: 1'b1, tuser: frame_bad};
                        pend_valid <= 1'b1;
                    end else if (hold_cnt == 2'd1) begin
                        out <= '{tdata: hold_new, tkeep: chk.beat.keep,
                                 tlast: 1'b1, tuser: frame_bad};
                        out_valid <= 1'b1;
                    end
                end else if (hold_cnt == 2'd2) begin
                    // hold_new is all FCS
                    out <= '{tdata: hold_old, tkeep: {DATA_NBYTES{1'b1}},
                             tlast: 1'b1, tuser: frame_bad};
                    out_valid <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== sim.f ====
+incdir+include
rtl/mac_rx_pkg.sv
rtl/rx_frame_delineate.sv
rtl/rx_fcs_check.sv
rtl/rx_stream_out.sv
rtl/mac_rx.sv
dv/tb_clock_gen.sv
dv/mac_rx_asserts.sv
dv/mac_rx_tb.sv
